//--- verilog/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Byte address and word width.
`define MEM_ADDR_BITS 15
`define MEM_DATA_BITS 32

// Bank geometry: 8 groups of 32 banks of 32 words.
`define MEM_GROUPS 8
`define MEM_BANKS_PER_GROUP 32
`define MEM_BANK_WORDS 32

// Low bit of each address field.
`define MEM_WORD_LSB 2
`define MEM_BANK_LSB 7
`define MEM_GROUP_LSB 12

// Cycles a strobe is held, and the width of the counter that times it.
`define SRAM_ACCESS_CYCLES 2
`define SRAM_CNT_BITS 2

`endif

//--- verilog/mem_pkg.sv
package mem_pkg;

    // Write size of a port request; 3 is not a legal encoding.
    typedef enum logic [1:0] {
        size_word = 2'd0,
        size_byte = 2'd1,
        size_half = 2'd2
    } mem_size_t;

    // Access sequencer states.
    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_stage,
        st_merge_write,
        st_direct_write
    } ctrl_state_t;

endpackage

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_arbiter import mem_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      a_en,
    input  logic                      a_rd_wr,
    input  mem_size_t                 a_wr_size,
    input  logic [`MEM_ADDR_BITS-1:0] a_addr,
    input  logic [`MEM_DATA_BITS-1:0] a_wdata,

    input  logic                      b_en,
    input  logic                      b_rd_wr,
    input  mem_size_t                 b_wr_size,
    input  logic [`MEM_ADDR_BITS-1:0] b_addr,
    input  logic [`MEM_DATA_BITS-1:0] b_wdata,

    input  logic                      done,

    output logic                      a_ready,
    output logic                      b_ready,
    output logic                      req_en,
    output logic                      req_rd_wr,
    output mem_size_t                 req_size,
    output logic [`MEM_ADDR_BITS-1:0] req_addr,
    output logic [`MEM_DATA_BITS-1:0] req_wdata
);

    logic busy;
    logic grant_b;
    logic last_b;
    logic pick_b;

    // Port b wins when it asks alone, or when both ask and a was served last.
    assign pick_b = b_en && (!a_en || !last_b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            grant_b <= 1'b0;
            last_b  <= 1'b1;
        end else if (!busy) begin
            if (a_en || b_en) begin
                busy    <= 1'b1;
                grant_b <= pick_b;
            end
        end else if (done) begin
            busy   <= 1'b0;
            last_b <= grant_b;
        end
    end

    assign req_en    = busy && (grant_b ? b_en : a_en);
    assign req_rd_wr = grant_b ? b_rd_wr   : a_rd_wr;
    assign req_size  = grant_b ? b_wr_size : a_wr_size;
    assign req_addr  = grant_b ? b_addr    : a_addr;
    assign req_wdata = grant_b ? b_wdata   : a_wdata;

    // Done goes back to the granted port only.
    assign a_ready = busy && !grant_b && done;
    assign b_ready = busy && grant_b && done;

endmodule

//--- verilog/mem_controller.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_controller import mem_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      req_en,
    input  logic                      req_rd_wr,
    input  mem_size_t                 req_size,
    input  logic [`MEM_ADDR_BITS-1:0] req_addr,
    input  logic                      sram_done,

    output logic                      done,
    output logic                      rd_start,
    output logic                      wr_start,
    output logic                      stage_load,
    output logic                      wr_from_merge
);

    ctrl_state_t state;
    logic        direct;

    // Only an aligned full word write can skip the read.
    assign direct = !req_rd_wr && (req_size == size_word) && (req_addr[1:0] == 2'b00);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            done     <= 1'b0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            done     <= 1'b0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;

            case (state)
                st_idle: begin
                    // The grant is still up in the done cycle, so wait it out.
                    if (req_en && !done) begin
                        if (direct) begin
                            state    <= st_direct_write;
                            wr_start <= 1'b1;
                        end else begin
                            state    <= st_read;
                            rd_start <= 1'b1;
                        end
                    end
                end

                st_read: begin
                    if (sram_done) begin
                        if (req_rd_wr) begin
                            state <= st_idle;
                            done  <= 1'b1;
                        end else begin
                            state <= st_stage;
                        end
                    end
                end

                // Old word is in the staging register; merged data settles here.
                st_stage: begin
                    state    <= st_merge_write;
                    wr_start <= 1'b1;
                end

                st_merge_write: begin
                    if (sram_done) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end

                st_direct_write: begin
                    if (sram_done) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Capture the array word on the read strobe's last cycle.
    assign stage_load = (state == st_read) && sram_done;

    assign wr_from_merge = (state == st_merge_write);

endmodule

//--- verilog/sram_timing.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module sram_timing (
    input  logic clk,
    input  logic rst_n,

    input  logic rd_start,
    input  logic wr_start,

    output logic ce,
    output logic oe,
    output logic we,
    output logic sram_done
);

    logic [`SRAM_CNT_BITS-1:0] cnt;

    // Strobes rise the cycle after a start and stay up for the access time.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ce  <= 1'b0;
            oe  <= 1'b0;
            we  <= 1'b0;
            cnt <= '0;
        end else if (rd_start || wr_start) begin
            ce  <= 1'b1;
            oe  <= rd_start;
            we  <= wr_start && !rd_start;
            cnt <= `SRAM_CNT_BITS'(`SRAM_ACCESS_CYCLES - 1);
        end else if (ce) begin
            if (cnt == '0) begin
                ce <= 1'b0;
                oe <= 1'b0;
                we <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Done marks the last strobe cycle, while read data is still driven.
    assign sram_done = ce && (cnt == '0);

endmodule

//--- verilog/sram_array.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module sram_array (
    input  logic                                    clk,
    input  logic [`MEM_ADDR_BITS-1:`MEM_WORD_LSB]   addr,
    input  logic                                    ce,
    input  logic                                    oe,
    input  logic                                    we,
    input  logic [`MEM_DATA_BITS-1:0]               wdata,

    output logic [`MEM_DATA_BITS-1:0]               rdata
);

    logic [`MEM_DATA_BITS-1:0] mem [`MEM_GROUPS][`MEM_BANKS_PER_GROUP][`MEM_BANK_WORDS];

    logic [$clog2(`MEM_GROUPS)-1:0]          group_sel;
    logic [$clog2(`MEM_BANKS_PER_GROUP)-1:0] bank_sel;
    logic [$clog2(`MEM_BANK_WORDS)-1:0]      word_sel;

    // Group, then bank within the group, then word within the bank.
    assign group_sel = addr[`MEM_GROUP_LSB +: $clog2(`MEM_GROUPS)];
    assign bank_sel  = addr[`MEM_BANK_LSB +: $clog2(`MEM_BANKS_PER_GROUP)];
    assign word_sel  = addr[`MEM_WORD_LSB +: $clog2(`MEM_BANK_WORDS)];

    always_ff @(posedge clk) begin
        if (ce && we) begin
            mem[group_sel][bank_sel][word_sel] <= wdata;
        end
    end

    // Bus reads as zero unless the bank is selected for output.
    assign rdata = (ce && oe) ? mem[group_sel][bank_sel][word_sel] : '0;

endmodule

//--- verilog/mem_align.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module mem_align import mem_pkg::*; (
    input  logic [`MEM_DATA_BITS-1:0] staged,
    input  logic [`MEM_DATA_BITS-1:0] wdata,
    input  mem_size_t                 size,
    input  logic [1:0]                offset,

    output logic [`MEM_DATA_BITS-1:0] merged
);

    // New data sits in the low bits of wdata and lands in the addressed lane.
    always_comb begin
        merged = staged;

        case (size)
            size_word: begin
                merged = wdata;
            end

            size_byte: begin
                merged[{offset, 3'b000} +: 8] = wdata[7:0];
            end

            size_half: begin
                merged[{offset[1], 4'b0000} +: 16] = wdata[15:0];
            end

            default: begin
                merged = staged;
            end
        endcase
    end

endmodule

//--- verilog/main_memory_top.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module main_memory_top import mem_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      a_en,
    input  logic                      a_rd_wr,
    input  mem_size_t                 a_wr_size,
    input  logic [`MEM_ADDR_BITS-1:0] a_addr,
    input  logic [`MEM_DATA_BITS-1:0] a_wdata,
    output logic [`MEM_DATA_BITS-1:0] a_rdata,
    output logic                      a_ready,

    input  logic                      b_en,
    input  logic                      b_rd_wr,
    input  mem_size_t                 b_wr_size,
    input  logic [`MEM_ADDR_BITS-1:0] b_addr,
    input  logic [`MEM_DATA_BITS-1:0] b_wdata,
    output logic [`MEM_DATA_BITS-1:0] b_rdata,
    output logic                      b_ready
);

    logic                      req_en;
    logic                      req_rd_wr;
    mem_size_t                 req_size;
    logic [`MEM_ADDR_BITS-1:0] req_addr;
    logic [`MEM_DATA_BITS-1:0] req_wdata;

    logic done;
    logic rd_start;
    logic wr_start;
    logic stage_load;
    logic wr_from_merge;

    logic ce;
    logic oe;
    logic we;
    logic sram_done;

    logic [`MEM_DATA_BITS-1:0] array_rdata;
    logic [`MEM_DATA_BITS-1:0] array_wdata;
    logic [`MEM_DATA_BITS-1:0] staged_word;
    logic [`MEM_DATA_BITS-1:0] merged_word;

    mem_arbiter mem_arbiter_inst (
        .clk(clk), .rst_n(rst_n),
        .a_en(a_en), .a_rd_wr(a_rd_wr), .a_wr_size(a_wr_size),
        .a_addr(a_addr), .a_wdata(a_wdata),
        .b_en(b_en), .b_rd_wr(b_rd_wr), .b_wr_size(b_wr_size),
        .b_addr(b_addr), .b_wdata(b_wdata),
        .done(done), .a_ready(a_ready), .b_ready(b_ready),
        .req_en(req_en), .req_rd_wr(req_rd_wr), .req_size(req_size),
        .req_addr(req_addr), .req_wdata(req_wdata)
    );

    mem_controller mem_controller_inst (
        .clk(clk), .rst_n(rst_n),
        .req_en(req_en), .req_rd_wr(req_rd_wr), .req_size(req_size),
        .req_addr(req_addr), .sram_done(sram_done),
        .done(done), .rd_start(rd_start), .wr_start(wr_start),
        .stage_load(stage_load), .wr_from_merge(wr_from_merge)
    );

    sram_timing sram_timing_inst (
        .clk(clk), .rst_n(rst_n),
        .rd_start(rd_start), .wr_start(wr_start),
        .ce(ce), .oe(oe), .we(we), .sram_done(sram_done)
    );

    sram_array sram_array_inst (
        .clk(clk),
        .addr(req_addr[`MEM_ADDR_BITS-1:`MEM_WORD_LSB]),
        .ce(ce), .oe(oe), .we(we),
        .wdata(array_wdata), .rdata(array_rdata)
    );

    mem_align mem_align_inst (
        .staged(staged_word), .wdata(req_wdata),
        .size(req_size), .offset(req_addr[1:0]),
        .merged(merged_word)
    );

    // Staging register holds read data and the old word of a read-modify-write.
    always_ff @(posedge clk) begin
        if (stage_load) begin
            staged_word <= array_rdata;
        end
    end

    assign array_wdata = wr_from_merge ? merged_word : req_wdata;

    assign a_rdata = staged_word;
    assign b_rdata = staged_word;

endmodule

//--- bench/main_memory_props.sv
`timescale 1ns/1ps

module main_memory_props import mem_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        a_en,
    input logic        b_en,
    input logic        a_ready,
    input logic        b_ready,
    input logic        oe,
    input logic        we,
    input ctrl_state_t ctrl_state
);

    // A port sees ready only while it holds its request.
    a_ready_needs_en: assert property (@(posedge clk) disable iff (!rst_n) a_ready |-> a_en)
        else $error("a_ready without a_en");
    b_ready_needs_en: assert property (@(posedge clk) disable iff (!rst_n) b_ready |-> b_en)
        else $error("b_ready without b_en");

    one_ready: assert property (@(posedge clk) disable iff (!rst_n) !(a_ready && b_ready))
        else $error("a_ready and b_ready high together");

    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n) a_ready |=> !a_ready)
        else $error("a_ready longer than one cycle");
    b_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n) b_ready |=> !b_ready)
        else $error("b_ready longer than one cycle");

    oe_we_apart: assert property (@(posedge clk) disable iff (!rst_n) !(oe && we))
        else $error("oe and we high together");

    // Strobes belong to the matching controller phase.
    we_in_write: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (ctrl_state == st_merge_write || ctrl_state == st_direct_write))
        else $error("we outside a write state");
    oe_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        oe |-> (ctrl_state == st_read))
        else $error("oe outside the read state");

endmodule

bind main_memory_top main_memory_props main_memory_props_inst (
    .clk(clk),
    .rst_n(rst_n),
    .a_en(a_en),
    .b_en(b_en),
    .a_ready(a_ready),
    .b_ready(b_ready),
    .oe(oe),
    .we(we),
    .ctrl_state(mem_controller_inst.state)
);

//--- bench/main_memory_tb.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module main_memory_tb import mem_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int RMW_CYCLES   = 2 * `SRAM_ACCESS_CYCLES + 4;
    // Own access plus one access of the other port and arbitration.
    localparam int WORST_CYCLES = 2 * RMW_CYCLES + 2;
    localparam int NUM_ACCESSES = 120;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + NUM_ACCESSES * WORST_CYCLES + 100) * CLK_PERIOD;
    localparam int STREAM_LEN   = 6;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      a_en;
    logic                      a_rd_wr;
    mem_size_t                 a_wr_size;
    logic [`MEM_ADDR_BITS-1:0] a_addr;
    logic [`MEM_DATA_BITS-1:0] a_wdata;
    logic [`MEM_DATA_BITS-1:0] a_rdata;
    logic                      a_ready;
    logic                      b_en;
    logic                      b_rd_wr;
    mem_size_t                 b_wr_size;
    logic [`MEM_ADDR_BITS-1:0] b_addr;
    logic [`MEM_DATA_BITS-1:0] b_wdata;
    logic [`MEM_DATA_BITS-1:0] b_rdata;
    logic                      b_ready;

    logic [`MEM_DATA_BITS-1:0] ref_mem [1 << (`MEM_ADDR_BITS - 2)];
    logic [31:0]               lfsr = 32'h273a;
    time                       seen_at [2];
    int                        last_served = 0;
    int                        reqs [2] = '{0, 0};
    int                        readies [2] = '{0, 0};
    int                        checks = 0;
    int                        errors = 0;
    int                        tests = 0;
    int                        test_errors = 0;

    main_memory_top main_memory_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        readies[0] += int'(a_ready);
        readies[1] += int'(b_ready);
    end

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [`MEM_ADDR_BITS-1:0] word_addr(input int group, input int bank,
                                                            input int off);
        logic [31:0] word;
        word = take_bits(5);
        return {group[2:0], bank[4:0], word[4:0], 2'(off)};
    endfunction

    // Word after a write lands under the byte, half and word lane rules.
    function automatic logic [31:0] expect_write(input logic [31:0] old, input logic [31:0] data,
                                                 input mem_size_t size, input logic [1:0] off);
        logic [31:0] mask;
        int          shift;
        mask = (size == size_byte) ? 32'hff : 32'hffff;
        shift = (size == size_byte) ? 8 * int'(off) : 16 * int'(off[1]);
        if (size == size_word) begin
            return data;
        end
        return (old & ~(mask << shift)) | ((data & mask) << shift);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic drive_port(input bit use_b, input logic en, input logic rd, input mem_size_t size,
                              input logic [`MEM_ADDR_BITS-1:0] addr, input logic [31:0] data);
        if (use_b) begin
            b_en = en;
            b_rd_wr = rd;
            b_wr_size = size;
            b_addr = addr;
            b_wdata = data;
        end else begin
            a_en = en;
            a_rd_wr = rd;
            a_wr_size = size;
            a_addr = addr;
            a_wdata = data;
        end
    endtask

    // Holds one request until ready, then releases en on the next falling edge.
    task automatic port_access(input bit use_b, input logic rd, input mem_size_t size,
                               input logic [`MEM_ADDR_BITS-1:0] addr, input logic [31:0] data,
                               output logic [31:0] rdata);
        int waited;
        waited = 0;
        reqs[use_b]++;
        drive_port(use_b, 1'b1, rd, size, addr, data);
        @(negedge clk);
        while (!(use_b ? b_ready : a_ready) && waited < 4 * WORST_CYCLES) begin
            waited++;
            @(negedge clk);
        end
        check_true(waited < 4 * WORST_CYCLES,
                   $sformatf("port %s got no ready for address %h", use_b ? "b" : "a", addr));
        rdata = use_b ? b_rdata : a_rdata;
        seen_at[use_b] = $time;
        last_served = int'(use_b);
        @(negedge clk);
        drive_port(use_b, 1'b0, rd, size, addr, data);
    endtask

    task automatic port_write(input bit use_b, input mem_size_t size,
                              input logic [`MEM_ADDR_BITS-1:0] addr, input logic [31:0] data);
        logic [31:0] rdata_ignored;
        port_access(use_b, 1'b0, size, addr, data, rdata_ignored);
        ref_mem[addr[`MEM_ADDR_BITS-1:2]] =
            expect_write(ref_mem[addr[`MEM_ADDR_BITS-1:2]], data, size, addr[1:0]);
    endtask

    task automatic port_read_check(input bit use_b, input logic [`MEM_ADDR_BITS-1:0] addr);
        logic [31:0] got;
        port_access(use_b, 1'b1, size_word, addr, '0, got);
        check_value(use_b ? "b_rdata" : "a_rdata", ref_mem[addr[`MEM_ADDR_BITS-1:2]], got);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic test_idle_after_reset();
        repeat (8) begin
            @(negedge clk);
            check_value("a_ready", 32'h0, 32'(a_ready));
            check_value("b_ready", 32'h0, 32'(b_ready));
        end
        finish_test("idle after reset");
    endtask

    task automatic test_word_both_ports();
        logic [`MEM_ADDR_BITS-1:0] addrs [32];
        for (int i = 0; i < 32; i++) begin
            addrs[i] = word_addr(i % 8, i, 0);
            port_write(i[0], size_word, addrs[i], take_bits(32));
        end
        for (int i = 0; i < 32; i++) begin
            port_read_check(!i[0], addrs[i]);
        end
        finish_test("word write and read");
    endtask

    task automatic test_byte_half_lanes();
        logic [`MEM_ADDR_BITS-1:0] base;
        base = word_addr(3, 17, 0);
        port_write(1'b0, size_word, base, take_bits(32));
        for (int lane = 0; lane < 4; lane++) begin
            port_write(1'b1, size_byte, {base[`MEM_ADDR_BITS-1:2], 2'(lane)}, take_bits(32));
            port_read_check(1'b0, base);
        end
        // Offsets 0 and 3 hit the low and high halves.
        for (int off = 0; off < 4; off += 3) begin
            port_write(1'b0, size_half, {base[`MEM_ADDR_BITS-1:2], 2'(off)}, take_bits(32));
            port_read_check(1'b1, base);
        end
        finish_test("byte and half lanes");
    endtask

    task automatic test_misaligned_word();
        logic [`MEM_ADDR_BITS-1:0] base;
        base = word_addr(6, 9, 0);
        for (int off = 1; off < 4; off++) begin
            port_write(off[0], size_word, {base[`MEM_ADDR_BITS-1:2], 2'(off)}, take_bits(32));
            port_read_check(!off[0], base);
        end
        finish_test("misaligned word");
    endtask

    task automatic test_dual_port();
        logic [`MEM_ADDR_BITS-1:0] addr [2][STREAM_LEN];
        logic [31:0]               data [2][STREAM_LEN];
        time                       ready_at [2][STREAM_LEN];
        int                        first;
        int                        second;
        // Each port streams into its own group; odd requests are misaligned.
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < STREAM_LEN; k++) begin
                addr[p][k] = word_addr(p + 4, k, k % 2);
                data[p][k] = take_bits(32);
            end
        end
        // The port that was not served last wins the first grant.
        first = 1 - last_served;
        second = 1 - first;
        fork
            begin
                for (int k = 0; k < STREAM_LEN; k++) begin
                    port_write(1'b0, size_word, addr[0][k], data[0][k]);
                    ready_at[0][k] = seen_at[0];
                end
            end
            begin
                for (int j = 0; j < STREAM_LEN; j++) begin
                    port_write(1'b1, size_word, addr[1][j], data[1][j]);
                    ready_at[1][j] = seen_at[1];
                end
            end
        join
        for (int k = 0; k < STREAM_LEN; k++) begin
            check_true(ready_at[first][k] < ready_at[second][k],
                       "grant order did not alternate between the ports");
            check_true(k == 0 || ready_at[second][k-1] < ready_at[first][k],
                       "one port was granted twice in a row while both requested");
        end
        for (int k = 0; k < STREAM_LEN; k++) begin
            port_read_check(1'b1, addr[0][k]);
            port_read_check(1'b0, addr[1][k]);
        end
        check_value("a_ready count", reqs[0], readies[0]);
        check_value("b_ready count", reqs[1], readies[1]);
        finish_test("dual port");
    endtask

    task automatic test_read_during_write();
        logic [`MEM_ADDR_BITS-1:0] addr;
        logic [31:0]               old_word;
        logic [31:0]               new_word;
        logic [31:0]               got;
        for (int lag = 0; lag < 3; lag++) begin
            addr = word_addr(7, 30 - lag, 0);
            old_word = take_bits(32);
            new_word = take_bits(32);
            port_write(1'b0, size_word, addr, old_word);
            fork
                port_write(1'b0, size_word, addr, new_word);
                begin
                    repeat (lag) @(negedge clk);
                    port_access(1'b1, 1'b1, size_word, addr, '0, got);
                end
            join
            // The port whose ready came first held the grant first.
            check_value("b_rdata", (seen_at[0] < seen_at[1]) ? new_word : old_word, got);
        end
        finish_test("read during write");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        drive_port(1'b0, 1'b0, 1'b1, size_word, '0, '0);
        drive_port(1'b1, 1'b0, 1'b1, size_word, '0, '0);
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        test_idle_after_reset();
        test_word_both_ports();
        test_byte_half_lanes();
        test_misaligned_word();
        test_dual_port();
        test_read_during_write();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_arbiter.sv
verilog/mem_controller.sv
verilog/sram_timing.sv
verilog/sram_array.sv
verilog/mem_align.sv
verilog/main_memory_top.sv
bench/main_memory_props.sv
bench/main_memory_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the pass message is printed.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f verilog.f --top-module main_memory_tb \
    && ./obj_dir/Vmain_memory_tb | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass" >&2; exit 1; }
